// ==== hdl/fifo_net_pkg.sv ====
// Shared widths, host word layout, channel tags and register map constants
`default_nettype none

package fifo_net_pkg;

    // ------------------------------------------------------------
    // Widths and host word markers
    // ------------------------------------------------------------
    localparam int DATA_W = 32;                     // Outgoing payload
    localparam int CTX_W  = 2;                      // Outgoing context

    localparam logic [7:0] HOST_MAGIC = 8'h77;      // Marks a valid host word

    localparam logic [1:0] TYPE_TLP  = 2'd0;        // Discarded
    localparam logic [1:0] TYPE_CFG  = 2'd1;        // Discarded
    localparam logic [1:0] TYPE_LOOP = 2'd2;
    localparam logic [1:0] TYPE_CMD  = 2'd3;

    // Outgoing channels, index 0 has top priority
    localparam int CHAN_LOOP = 0;
    localparam int CHAN_CMD  = 1;
    localparam int NUM_CHAN  = 2;
    localparam logic [NUM_CHAN-1:0][1:0] CHAN_TAG = {2'b11, 2'b10};

    // ------------------------------------------------------------
    // Register file layout
    // ------------------------------------------------------------
    localparam int ADDR_RW_BIT       = 15;          // Selects RW bank
    localparam int ADDR_SHADOW_BIT   = 14;          // Shadow space, ignored
    localparam int RO_BITS           = 128;
    localparam int RW_BITS           = 128;
    localparam logic [15:0] RO_MAGIC = 16'hab89;
    localparam logic [15:0] RW_MAGIC = 16'hefcd;
    localparam int RW_POS_SENDCNT_EN = 17;          // Enable bit in byte 2
    localparam int RW_POS_SENDCNT    = 32;          // 16-bit count at byte 4
    localparam logic [15:0] RESP_ADDR_SENDCNT = 16'hfffe;

    // One 64-bit host word, decoded as loopback or as command
    typedef union packed {
        struct packed {
            logic [DATA_W-1:0] payload;             // Upper half
            logic [19:0]       spare;
            logic [CTX_W-1:0]  ctx;
            logic [1:0]        typ;
            logic [7:0]        magic;
        } loop;
        struct packed {
            logic [15:0]       value;               // Bits 63:48
            logic [15:0]       mask;                // Bits 47:32
            logic [15:0]       addr;                // Byte address
            logic [1:0]        spare;
            logic              wr;                  // Bit 13
            logic              rd;                  // Bit 12
            logic [CTX_W-1:0]  ctx;
            logic [1:0]        typ;
            logic [7:0]        magic;
        } cmd;
    } host_word_u;

endpackage

`default_nettype wire

// ==== hdl/chan_if.sv ====
// Interface for one outgoing channel with source and sink modports
`timescale 1ns/10ps
`default_nettype none

interface chan_if;

    logic [fifo_net_pkg::DATA_W-1:0] data;      // Word payload
    logic [fifo_net_pkg::CTX_W-1:0]  ctx;       // Carried next to the word
    logic                            valid;
    logic                            ready;

    // Producer side
    modport source (
        output data,
        output ctx,
        output valid,
        input  ready
    );

    // Consumer side
    modport sink (
        input  data,
        input  ctx,
        input  valid,
        output ready
    );

endinterface

`default_nettype wire

// ==== hdl/ctl_regs.sv ====
// Control register file with read-only and read-write banks, command execution, send count
`timescale 1ns/10ps
`default_nettype none

module ctl_regs #(
    parameter int VERSION_MAJOR = 0,
    parameter int VERSION_MINOR = 0,
    parameter int DEVICE_ID     = 0
) (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 i_cmd_valid,
    input  wire fifo_net_pkg::host_word_u       i_cmd,
    input  wire                                 i_resp_ready,
    output logic                                o_resp_valid,
    output logic [fifo_net_pkg::DATA_W-1:0]     o_resp
);

    localparam int BANK_BITS = (fifo_net_pkg::RO_BITS > fifo_net_pkg::RW_BITS) ?
                               fifo_net_pkg::RO_BITS : fifo_net_pkg::RW_BITS;
    localparam int IDX_W     = $clog2(BANK_BITS);
    localparam logic [fifo_net_pkg::RW_BITS-1:0] RW_INIT =
        {{(fifo_net_pkg::RW_BITS-16){1'b0}}, fifo_net_pkg::RW_MAGIC};

    logic [fifo_net_pkg::RO_BITS-1:0]    ro;
    logic [fifo_net_pkg::RW_BITS-1:0]    rw;
    logic [fifo_net_pkg::RO_BITS+15:0]   ro_ext;     // Padded for reads near the top
    logic [fifo_net_pkg::RW_BITS+15:0]   rw_ext;
    logic [15:0]                         cmd_addr;
    logic [17:0]                         bit_pos;    // Byte address in bits
    logic [IDX_W-1:0]                    bit_idx;
    logic                                f_rw;
    logic                                f_shadow;
    logic                                in_range;
    logic [15:0]                         rd_data;
    logic                                rd_cmd;
    logic                                wr_cmd;
    logic [15:0]                         send_cnt;
    logic                                cnt_fire;

    // ------------------------------------------------------------
    // Read-only bank
    // ------------------------------------------------------------
    always_comb begin
        ro          = '0;
        ro[15:0]    = fifo_net_pkg::RO_MAGIC;               // +000
        ro[63:32]   = 32'(fifo_net_pkg::RO_BITS / 8);       // +004 byte size
        ro[71:64]   = 8'(VERSION_MAJOR);                    // +008
        ro[79:72]   = 8'(VERSION_MINOR);                    // +009
        ro[87:80]   = 8'(DEVICE_ID);                        // +00A
    end

    assign ro_ext = {16'h0000, ro};
    assign rw_ext = {16'h0000, rw};

    // ------------------------------------------------------------
    // Command decode
    // ------------------------------------------------------------
    assign cmd_addr = i_cmd.cmd.addr;
    assign bit_pos  = {cmd_addr[14:0], 3'b000};
    assign bit_idx  = bit_pos[IDX_W-1:0];
    assign f_rw     = cmd_addr[fifo_net_pkg::ADDR_RW_BIT];
    assign f_shadow = cmd_addr[fifo_net_pkg::ADDR_SHADOW_BIT];
    assign in_range = f_rw ? (bit_pos < fifo_net_pkg::RW_BITS)
                           : (bit_pos < fifo_net_pkg::RO_BITS);

    always_comb begin
        rd_data = 16'h0000;                                 // Past the bank
        if (in_range) begin
            if (f_rw) begin
                rd_data = rw_ext[bit_idx +: 16];
            end else begin
                rd_data = ro_ext[bit_idx +: 16];
            end
        end
    end

    assign rd_cmd = i_cmd_valid & i_cmd.cmd.rd & ~f_shadow;
    assign wr_cmd = i_cmd_valid & i_cmd.cmd.wr & ~f_shadow & f_rw;  // RW bank only

    // Send count runs only in idle command slots
    assign send_cnt = rw[fifo_net_pkg::RW_POS_SENDCNT +: 16];
    assign cnt_fire = ~i_cmd_valid & i_resp_ready
                    & rw[fifo_net_pkg::RW_POS_SENDCNT_EN] & (send_cnt != 16'h0000);

    // ------------------------------------------------------------
    // Register writes and response handshake
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rw           <= RW_INIT;
            o_resp_valid <= 1'b0;
        end else begin
            if (rd_cmd | cnt_fire) begin
                o_resp_valid <= 1'b1;
            end else if (i_resp_ready) begin
                o_resp_valid <= 1'b0;                       // Drained
            end

            if (cnt_fire) begin
                rw[fifo_net_pkg::RW_POS_SENDCNT +: 16] <= send_cnt - 16'd1;
            end else if (wr_cmd) begin
                // Masked bit by bit, clipped at the bank end
                for (int i = 0; i < 16; i++) begin
                    if (i_cmd.cmd.mask[i] && (int'(bit_pos) + i < fifo_net_pkg::RW_BITS)) begin
                        rw[int'(bit_idx) + i] <= i_cmd.cmd.value[i];
                    end
                end
            end
        end
    end

    // Response word, address high and value low
    always_ff @(posedge clk) begin
        if (rd_cmd) begin
            o_resp <= {cmd_addr, rd_data};
        end else if (cnt_fire) begin
            o_resp <= {fifo_net_pkg::RESP_ADDR_SENDCNT, send_cnt};
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rx_dispatch.sv ====
// Host word decoder, routing loopback words and command responses into channels
`timescale 1ns/10ps
`default_nettype none

module rx_dispatch #(
    parameter int VERSION_MAJOR = 0,
    parameter int VERSION_MINOR = 0,
    parameter int DEVICE_ID     = 0
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             i_rx_valid,
    input  wire fifo_net_pkg::host_word_u   i_rx_data,
    output logic                            o_rx_ready,
    chan_if.source                          o_chan [fifo_net_pkg::NUM_CHAN]
);

    logic                            loop_ready;
    logic                            cmd_ready;
    logic                            magic_ok;
    logic                            is_loop;
    logic                            is_cmd;
    logic                            cmd_valid;
    logic                            resp_valid;
    logic [fifo_net_pkg::DATA_W-1:0] resp;

    assign loop_ready = o_chan[fifo_net_pkg::CHAN_LOOP].ready;
    assign cmd_ready  = o_chan[fifo_net_pkg::CHAN_CMD].ready;
    assign magic_ok   = (i_rx_data.loop.magic == fifo_net_pkg::HOST_MAGIC);

    // Type decode, only for words with the magic byte
    always_comb begin
        is_loop = 1'b0;
        is_cmd  = 1'b0;
        if (magic_ok) begin
            case (i_rx_data.loop.typ)
                fifo_net_pkg::TYPE_LOOP: is_loop = 1'b1;
                fifo_net_pkg::TYPE_CMD:  is_cmd  = 1'b1;
                fifo_net_pkg::TYPE_TLP,
                fifo_net_pkg::TYPE_CFG: ;                   // No PCIe side, dropped
            endcase
        end
    end

    // Bad magic and dropped types are swallowed at once
    assign o_rx_ready = is_loop ? loop_ready : (is_cmd ? cmd_ready : 1'b1);

    // Command taken only with room for its response
    assign cmd_valid = i_rx_valid & is_cmd & cmd_ready;

    // Loopback goes straight into its channel
    assign o_chan[fifo_net_pkg::CHAN_LOOP].valid = i_rx_valid & is_loop;
    assign o_chan[fifo_net_pkg::CHAN_LOOP].data  = i_rx_data.loop.payload;
    assign o_chan[fifo_net_pkg::CHAN_LOOP].ctx   = i_rx_data.loop.ctx;

    ctl_regs #(
        .VERSION_MAJOR (VERSION_MAJOR),
        .VERSION_MINOR (VERSION_MINOR),
        .DEVICE_ID     (DEVICE_ID)
    ) u_ctl_regs (
        .clk          (clk),
        .rst          (rst),
        .i_cmd_valid  (cmd_valid),
        .i_cmd        (i_rx_data),
        .i_resp_ready (cmd_ready),
        .o_resp_valid (resp_valid),
        .o_resp       (resp)
    );

    // Responses carry no context
    assign o_chan[fifo_net_pkg::CHAN_CMD].valid = resp_valid;
    assign o_chan[fifo_net_pkg::CHAN_CMD].data  = resp;
    assign o_chan[fifo_net_pkg::CHAN_CMD].ctx   = '0;

endmodule

`default_nettype wire

// ==== hdl/chan_fifo.sv ====
// Synchronous circular FIFO for one outgoing channel
`timescale 1ns/10ps
`default_nettype none

module chan_fifo #(
    parameter int DEPTH = 4
) (
    input  wire     clk,
    input  wire     rst,
    chan_if.sink    i_wr,
    chan_if.source  o_rd
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [fifo_net_pkg::DATA_W-1:0] data_mem [DEPTH];
    logic [fifo_net_pkg::CTX_W-1:0]  ctx_mem  [DEPTH];
    logic [PTR_W-1:0]                wr_ptr;
    logic [PTR_W-1:0]                rd_ptr;
    logic [CNT_W-1:0]                count;
    logic                            push;
    logic                            pop;

    assign i_wr.ready = (count != CNT_W'(DEPTH));       // Not full
    assign o_rd.valid = (count != '0);                  // Not empty
    assign o_rd.data  = data_mem[rd_ptr];
    assign o_rd.ctx   = ctx_mem[rd_ptr];

    assign push = i_wr.valid & i_wr.ready;
    assign pop  = o_rd.valid & o_rd.ready;

    // Storage, no reset
    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr] <= i_wr.data;
            ctx_mem[wr_ptr]  <= i_wr.ctx;
        end
    end

    // Pointers wrap at DEPTH, need not be a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tx_arbiter.sv ====
// Fixed-priority arbiter draining the channel FIFOs onto the host output
`timescale 1ns/10ps
`default_nettype none

module tx_arbiter (
    input  wire                                 clk,
    input  wire                                 rst,
    chan_if.sink                                i_chan [fifo_net_pkg::NUM_CHAN],
    output logic                                o_tx_valid,
    input  wire                                 i_tx_ready,
    output logic [fifo_net_pkg::DATA_W-1:0]     o_tx_data,
    output logic [1:0]                          o_tx_tag,
    output logic [fifo_net_pkg::CTX_W-1:0]      o_tx_ctx
);

    localparam int SEL_W = (fifo_net_pkg::NUM_CHAN > 1) ? $clog2(fifo_net_pkg::NUM_CHAN) : 1;

    logic [fifo_net_pkg::NUM_CHAN-1:0]                             valid_v;
    logic [fifo_net_pkg::NUM_CHAN-1:0][fifo_net_pkg::DATA_W-1:0]   data_v;
    logic [fifo_net_pkg::NUM_CHAN-1:0][fifo_net_pkg::CTX_W-1:0]    ctx_v;
    logic [SEL_W-1:0]                                              pick;
    logic [SEL_W-1:0]                                              grant;
    logic [SEL_W-1:0]                                              grant_q;
    logic                                                          stall_q;

    // Flatten channel heads, pop only the granted one
    for (genvar g = 0; g < fifo_net_pkg::NUM_CHAN; g++) begin : g_tap
        assign valid_v[g]     = i_chan[g].valid;
        assign data_v[g]      = i_chan[g].data;
        assign ctx_v[g]       = i_chan[g].ctx;
        assign i_chan[g].ready = i_tx_ready & (grant == SEL_W'(g));
    end

    // Lowest index with data wins
    always_comb begin
        pick = '0;
        for (int i = fifo_net_pkg::NUM_CHAN - 1; i >= 0; i--) begin
            if (valid_v[i]) begin
                pick = SEL_W'(i);
            end
        end
    end

    assign grant = stall_q ? grant_q : pick;            // Held across a stall

    assign o_tx_valid = valid_v[grant];
    assign o_tx_data  = data_v[grant];
    assign o_tx_ctx   = ctx_v[grant];
    assign o_tx_tag   = fifo_net_pkg::CHAN_TAG[grant];

    always_ff @(posedge clk) begin
        if (rst) begin
            stall_q <= 1'b0;
            grant_q <= '0;
        end else begin
            stall_q <= o_tx_valid & ~i_tx_ready;
            grant_q <= grant;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fifo_net_top.sv ====
// Top level of the host FIFO network with dispatcher, channel FIFOs and output arbiter
`timescale 1ns/10ps
`default_nettype none

module fifo_net_top #(
    parameter int FIFO_DEPTH    = 4,
    parameter int VERSION_MAJOR = 0,
    parameter int VERSION_MINOR = 0,
    parameter int DEVICE_ID     = 0
) (
    input  wire                                 clk,
    input  wire                                 rst,
    // Host input
    input  wire                                 i_rx_valid,
    output logic                                o_rx_ready,
    input  wire [63:0]                          i_rx_data,
    // Host output
    output logic                                o_tx_valid,
    input  wire                                 i_tx_ready,
    output logic [fifo_net_pkg::DATA_W-1:0]     o_tx_data,
    output logic [1:0]                          o_tx_tag,
    output logic [fifo_net_pkg::CTX_W-1:0]      o_tx_ctx
);

    // Dispatcher to FIFOs, and FIFOs to arbiter
    chan_if rx_chan [fifo_net_pkg::NUM_CHAN] ();
    chan_if tx_chan [fifo_net_pkg::NUM_CHAN] ();

    rx_dispatch #(
        .VERSION_MAJOR (VERSION_MAJOR),
        .VERSION_MINOR (VERSION_MINOR),
        .DEVICE_ID     (DEVICE_ID)
    ) u_rx_dispatch (
        .clk        (clk),
        .rst        (rst),
        .i_rx_valid (i_rx_valid),
        .i_rx_data  (i_rx_data),
        .o_rx_ready (o_rx_ready),
        .o_chan     (rx_chan)
    );

    // One FIFO per outgoing channel
    for (genvar g = 0; g < fifo_net_pkg::NUM_CHAN; g++) begin : g_chan
        chan_fifo #(
            .DEPTH (FIFO_DEPTH)
        ) u_chan_fifo (
            .clk  (clk),
            .rst  (rst),
            .i_wr (rx_chan[g]),
            .o_rd (tx_chan[g])
        );
    end

    tx_arbiter u_tx_arbiter (
        .clk        (clk),
        .rst        (rst),
        .i_chan     (tx_chan),
        .o_tx_valid (o_tx_valid),
        .i_tx_ready (i_tx_ready),
        .o_tx_data  (o_tx_data),
        .o_tx_tag   (o_tx_tag),
        .o_tx_ctx   (o_tx_ctx)
    );

endmodule

`default_nettype wire

// ==== verification/fifo_net_properties.sv ====
// Concurrent assertions on the host output handshake, bound to the top level
`timescale 1ns/10ps
`default_nettype none

module fifo_net_properties (
    input wire                                 clk,
    input wire                                 rst,
    input wire                                 i_rx_valid,
    input wire                                 o_rx_ready,
    input wire                                 o_tx_valid,
    input wire                                 i_tx_ready,
    input wire [fifo_net_pkg::DATA_W-1:0]      o_tx_data,
    input wire [1:0]                           o_tx_tag,
    input wire [fifo_net_pkg::CTX_W-1:0]       o_tx_ctx
);

    logic seen_input;                               // Host word taken since reset

    always_ff @(posedge clk) begin
        if (rst) begin
            seen_input <= 1'b0;
        end else if (i_rx_valid && o_rx_ready) begin
            seen_input <= 1'b1;
        end
    end

    // Quiet output once reset has held for a clock
    a_reset_quiet: assert property (@(posedge clk) (rst && $past(rst)) |-> !o_tx_valid)
        else $error("o_tx_valid high in reset");

    // Stalled word held intact
    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        (o_tx_valid && !i_tx_ready) |=> (o_tx_valid && $stable(o_tx_data)
                                         && $stable(o_tx_tag) && $stable(o_tx_ctx)))
        else $error("output changed during a stall");

    a_no_spurious: assert property (@(posedge clk) disable iff (rst)
        (o_tx_valid && i_tx_ready) |-> seen_input)
        else $error("output transfer with no host word before it");

endmodule

bind fifo_net_top fifo_net_properties u_fifo_net_properties (
    .clk        (clk),
    .rst        (rst),
    .i_rx_valid (i_rx_valid),
    .o_rx_ready (o_rx_ready),
    .o_tx_valid (o_tx_valid),
    .i_tx_ready (i_tx_ready),
    .o_tx_data  (o_tx_data),
    .o_tx_tag   (o_tx_tag),
    .o_tx_ctx   (o_tx_ctx)
);

`default_nettype wire

// ==== verification/tb_fifo_net.sv ====
// Directed tests, compare tasks, output collector and watchdog for the host FIFO network
`timescale 1ns/10ps
`default_nettype none

module tb_fifo_net;

    localparam int FIFO_DEPTH = 4;
    localparam int V_MAJOR    = 4;
    localparam int V_MINOR    = 14;
    localparam int DEV_ID     = 3;
    localparam int CLK_PERIOD = 40;
    localparam int NUM_TESTS  = 6;
    localparam int LIMIT_NS   = NUM_TESTS * 2000;   // Whole run budget
    localparam int WAIT_MAX   = 200;                // Cycles allowed for expected output
    localparam logic [1:0] TAG_LOOP = 2'b10;
    localparam logic [1:0] TAG_CMD  = 2'b11;

    // One transfer on the host output
    typedef struct packed {
        logic [1:0]                      tag;
        logic [fifo_net_pkg::CTX_W-1:0]  ctx;
        logic [fifo_net_pkg::DATA_W-1:0] data;
    } out_t;

    logic                            clk;
    logic                            rst;
    logic                            i_rx_valid;
    logic                            o_rx_ready;
    logic [63:0]                     i_rx_data;
    logic                            o_tx_valid;
    logic                            i_tx_ready;
    logic [fifo_net_pkg::DATA_W-1:0] o_tx_data;
    logic [1:0]                      o_tx_tag;
    logic [fifo_net_pkg::CTX_W-1:0]  o_tx_ctx;

    out_t        out_q [$];        // Seen on the host output
    out_t        exp_q [$];        // Predicted from the register map
    int          errors;
    int          checks;
    int          tests;
    int          err_mark;         // Error count at the start of a test

    fifo_net_top #(
        .FIFO_DEPTH    (FIFO_DEPTH),
        .VERSION_MAJOR (V_MAJOR),
        .VERSION_MINOR (V_MINOR),
        .DEVICE_ID     (DEV_ID)
    ) u_fifo_net_top (
        .clk        (clk),
        .rst        (rst),
        .i_rx_valid (i_rx_valid),
        .o_rx_ready (o_rx_ready),
        .i_rx_data  (i_rx_data),
        .o_tx_valid (o_tx_valid),
        .i_tx_ready (i_tx_ready),
        .o_tx_data  (o_tx_data),
        .o_tx_tag   (o_tx_tag),
        .o_tx_ctx   (o_tx_ctx)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Output collector sampling mid-cycle on settled signals
    always @(negedge clk) begin
        if (!rst && o_tx_valid && i_tx_ready) begin
            out_q.push_back('{tag: o_tx_tag, ctx: o_tx_ctx, data: o_tx_data});
        end
    end

    // Watchdog
    initial begin
        #(LIMIT_NS);
        $display("Watchdog expired after %0d ns, run stopped", LIMIT_NS);
        $display("Something failed");
        $finish;
    end

    // ------------------------------------------------------------
    // Word builders
    // ------------------------------------------------------------
    function automatic logic [63:0] loop_word(input logic [7:0] magic, input logic [1:0] typ,
                                              input logic [1:0] ctx, input logic [31:0] payload);
        fifo_net_pkg::host_word_u w;
        w              = '0;
        w.loop.magic   = magic;
        w.loop.typ     = typ;
        w.loop.ctx     = ctx;
        w.loop.payload = payload;
        return w;
    endfunction

    function automatic logic [63:0] cmd_word(input logic rd, input logic wr,
                                             input logic [15:0] addr, input logic [15:0] mask,
                                             input logic [15:0] value);
        fifo_net_pkg::host_word_u w;
        w           = '0;
        w.cmd.magic = fifo_net_pkg::HOST_MAGIC;
        w.cmd.typ   = fifo_net_pkg::TYPE_CMD;
        w.cmd.ctx   = 2'd1;                 // Responses must come back with ctx zero
        w.cmd.rd    = rd;
        w.cmd.wr    = wr;
        w.cmd.addr  = addr;
        w.cmd.mask  = mask;
        w.cmd.value = value;
        return w;
    endfunction

    // ------------------------------------------------------------
    // Drivers and compare tasks
    // ------------------------------------------------------------
    // Word stays valid up to the rising edge that sees o_rx_ready high
    task automatic send_word(input logic [63:0] w);
        @(posedge clk);
        i_rx_valid <= 1'b1;
        i_rx_data  <= w;
        @(negedge clk);
        while (!o_rx_ready) @(negedge clk);
        @(posedge clk);
        i_rx_valid <= 1'b0;
    endtask

    task automatic expect_out(input logic [1:0] tag, input logic [1:0] ctx,
                              input logic [31:0] data);
        exp_q.push_back('{tag: tag, ctx: ctx, data: data});
    endtask

    task automatic check_word(input string name, input logic [fifo_net_pkg::DATA_W-1:0] got,
                              input logic [fifo_net_pkg::DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_tag(input string name, input logic [1:0] got, input logic [1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t ns %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_ctx(input string name, input logic [fifo_net_pkg::CTX_W-1:0] got,
                             input logic [fifo_net_pkg::CTX_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t ns %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic wait_outputs(input int n);
        int cycles;
        cycles = 0;
        while (out_q.size() < n && cycles < WAIT_MAX) begin
            @(posedge clk);
            cycles++;
        end
        if (out_q.size() < n) begin
            errors++;
            $display("Timeout at %0t ns, only %0d of %0d output words arrived",
                     $time, out_q.size(), n);
        end
    endtask

    // Pairs collected words with predictions in order
    task automatic drain_and_compare();
        out_t o;
        out_t e;
        while (exp_q.size() > 0) begin
            if (out_q.size() == 0) begin
                errors++;
                $display("Missing %0d output words at %0t ns", exp_q.size(), $time);
                break;
            end
            o = out_q.pop_front();
            e = exp_q.pop_front();
            check_word("o_tx_data", o.data, e.data);
            check_tag("o_tx_tag", o.tag, e.tag);
            check_ctx("o_tx_ctx", o.ctx, e.ctx);
        end
        if (out_q.size() != 0) begin
            errors++;
            $display("%0d extra output words at %0t ns", out_q.size(), $time);
        end
        exp_q.delete();
        out_q.delete();
    endtask

    task automatic expect_silence(input int cycles);
        repeat (cycles) @(posedge clk);
        if (out_q.size() != 0) begin
            errors++;
            $display("%0d unexpected output words within %0d cycles", out_q.size(), cycles);
        end
        out_q.delete();
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("%-14s finished with %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic loopback_order();
        logic [31:0] pay;
        logic [1:0]  ctx;
        for (int i = 0; i < 8; i++) begin
            pay = $urandom();
            ctx = 2'($urandom());
            expect_out(TAG_LOOP, ctx, pay);
            send_word(loop_word(8'h77, 2'd2, ctx, pay));
        end
        wait_outputs(exp_q.size());
        drain_and_compare();
        report_test("loopback");
    endtask

    // Bad magic and PCIe types vanish
    task automatic filter_drop();
        logic [63:0] w;
        send_word(loop_word(8'h76, 2'd2, 2'd1, 32'hdead_beef));
        send_word(loop_word(8'h77, 2'd0, 2'd2, 32'h1111_2222));   // TLP
        send_word(loop_word(8'h77, 2'd1, 2'd3, 32'h3333_4444));   // CFG
        w      = cmd_word(1'b1, 1'b0, 16'h0000, 16'h0000, 16'h0000);
        w[7:0] = 8'hf7;
        send_word(w);
        expect_silence(50);
        report_test("filter");
    endtask

    task automatic register_read();
        expect_out(TAG_CMD, 2'd0, {16'h0000, 16'hab89});          // RO magic
        expect_out(TAG_CMD, 2'd0, {16'h0004, 16'h0010});          // Byte size
        expect_out(TAG_CMD, 2'd0, {16'h0008, 8'(V_MINOR), 8'(V_MAJOR)});
        expect_out(TAG_CMD, 2'd0, {16'h000a, 8'h00, 8'(DEV_ID)});
        expect_out(TAG_CMD, 2'd0, {16'h8000, 16'hefcd});          // RW magic
        expect_out(TAG_CMD, 2'd0, {16'h0010, 16'h0000});          // Past RO end
        expect_out(TAG_CMD, 2'd0, {16'h8040, 16'h0000});          // Past RW end
        send_word(cmd_word(1'b1, 1'b0, 16'h0000, 16'h0000, 16'h0000));
        send_word(cmd_word(1'b1, 1'b0, 16'h0004, 16'h0000, 16'h0000));
        send_word(cmd_word(1'b1, 1'b0, 16'h0008, 16'h0000, 16'h0000));
        send_word(cmd_word(1'b1, 1'b0, 16'h000a, 16'h0000, 16'h0000));
        send_word(cmd_word(1'b1, 1'b0, 16'h8000, 16'h0000, 16'h0000));
        send_word(cmd_word(1'b1, 1'b0, 16'h0010, 16'h0000, 16'h0000));
        send_word(cmd_word(1'b1, 1'b0, 16'h8040, 16'h0000, 16'h0000));
        wait_outputs(exp_q.size());
        drain_and_compare();
        report_test("register_read");
    endtask

    // Free RW word at byte 8
    task automatic masked_write();
        logic [15:0] old_val;
        logic [15:0] new_val;
        logic [15:0] mask;
        old_val = 16'($urandom());
        new_val = 16'($urandom());
        mask    = 16'h3c5a;
        send_word(cmd_word(1'b0, 1'b1, 16'h8008, 16'hffff, old_val));
        send_word(cmd_word(1'b0, 1'b1, 16'h8008, mask, new_val));
        expect_out(TAG_CMD, 2'd0, {16'h8008, (old_val & ~mask) | (new_val & mask)});
        send_word(cmd_word(1'b1, 1'b0, 16'h8008, 16'h0000, 16'h0000));
        wait_outputs(exp_q.size());
        drain_and_compare();
        report_test("masked_write");
    endtask

    task automatic send_count();
        int n;
        n = 5;
        send_word(cmd_word(1'b0, 1'b1, 16'h8004, 16'hffff, 16'(n)));     // Count first
        send_word(cmd_word(1'b0, 1'b1, 16'h8002, 16'h0002, 16'h0002));   // Then enable
        for (int i = n; i >= 1; i--) begin
            expect_out(TAG_CMD, 2'd0, {16'hfffe, 16'(i)});
        end
        wait_outputs(exp_q.size());
        drain_and_compare();
        expect_silence(20);                                 // Count exhausted
        report_test("send_count");
    endtask

    task automatic back_pressure();
        logic [63:0] words [16];
        logic [31:0] pay;
        logic [1:0]  ctx;
        logic        stalled;
        stalled = 1'b0;
        for (int i = 0; i < 16; i++) begin
            pay      = $urandom();
            ctx      = 2'($urandom());
            words[i] = loop_word(8'h77, 2'd2, ctx, pay);
            expect_out(TAG_LOOP, ctx, pay);
        end
        @(posedge clk);
        i_tx_ready <= 1'b0;
        fork
            begin
                for (int i = 0; i < 16; i++) send_word(words[i]);
            end
            begin
                repeat (20) begin
                    @(negedge clk);
                    if (i_rx_valid && !o_rx_ready) stalled = 1'b1;
                end
                @(posedge clk);
                i_tx_ready <= 1'b1;                         // Release the output
            end
        join
        if (!stalled) begin
            errors++;
            $display("o_rx_ready never dropped while the output was held");
        end
        wait_outputs(exp_q.size());
        drain_and_compare();
        report_test("back_pressure");
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        void'($urandom(1));
        errors     = 0;
        checks     = 0;
        tests      = 0;
        err_mark   = 0;
        rst        = 1'b1;
        i_rx_valid = 1'b0;
        i_rx_data  = '0;
        i_tx_ready = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        loopback_order();
        filter_drop();
        register_read();
        masked_write();
        send_count();
        back_pressure();

        repeat (4) @(posedge clk);
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
hdl/fifo_net_pkg.sv
hdl/chan_if.sv
hdl/ctl_regs.sv
hdl/rx_dispatch.sv
hdl/chan_fifo.sv
hdl/tx_arbiter.sv
hdl/fifo_net_top.sv
verification/fifo_net_properties.sv
verification/tb_fifo_net.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_fifo_net -f list.f || exit 1
out="$(./obj_dir/Vtb_fifo_net 2>&1)"
echo "$out"
echo "$out" | grep -qx "Everything OK" && echo "simulation passed" \
    || { echo "simulation did not pass"; exit 1; }
